//--- logic/sio_cfg_pkg.sv
/*
 * serial output port constants
 * register field encoding for sioc, srta and sdx
 * output clock divider counts for the fixed configuration
 */
package sio_cfg_pkg;

    // register select carried on r_field
    typedef enum logic [2:0] {
        reg_sioc = 3'd0,    // serial i/o control, stored only
        reg_srta = 3'd1,    // serial address
        reg_sdx  = 3'd2     // serial data, write side feeds the output buffer
    } sio_reg_e;

    localparam int SIO_WORD_W = 16;    // bits per serial word
    localparam int SIOC_W     = 10;    // config register width
    localparam int SRTA_W     = 8;     // address shifted out on sadd

    // ock is built from ph1 ticks
    // one period is OCK_DIV ticks, i.e. 12 clk cycles
    localparam int OCK_DIV    = 6;
    localparam int OCK_RISE   = 2;     // divider count for the rising edge
    localparam int OCK_FALL   = 5;     // divider count for the falling edge
    localparam int OCK_DIV_W  = $clog2(OCK_DIV);

    // the fixed configuration amounts to:
    //   ock = clk / 12, msb first, 16 bit words
    //   ock and old driven by the port, serial input unused
    // so the sioc contents never change the behaviour

endpackage

//--- logic/sio_cmd_pkg.sv
/*
 * host command unit definitions
 * opcode encoding and data ram sizes
 */
package sio_cmd_pkg;

    // host opcodes, one per command beat
    typedef enum logic [2:0] {
        op_set_acc  = 3'd0,    // acc <= cmd_data
        op_set_ram  = 3'd1,    // ram[cmd_addr] <= cmd_data
        op_load_imm = 3'd2,    // port register <= cmd_data
        op_load_acc = 3'd3,    // port register <= acc
        op_load_ram = 3'd4,    // port register <= ram[cmd_addr]
        op_read     = 3'd5     // read back port register on rd_data
    } sio_op_e;

    // small data ram standing in for the core's data memory
    localparam int RAM_DEPTH = 8;
    localparam int RAM_AW    = $clog2(RAM_DEPTH);

    // loads are the only opcodes that pulse a strobe toward the port
    // set_* ops touch local storage only, op_read samples r_sio

endpackage

//--- logic/sio_cmd_unit.sv
/*
 * host command unit
 * ph1 phase generator and command acceptance with obe stall
 * accumulator and eight word data ram
 * load strobes toward the serial port and registered read-back
 */
module sio_cmd_unit
    import sio_cfg_pkg::*;
    import sio_cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // host command port
    input  logic                  cmd_valid,
    input  sio_op_e               cmd_op,
    input  sio_reg_e              cmd_reg,
    input  logic [RAM_AW-1:0]     cmd_addr,
    input  logic [SIO_WORD_W-1:0] cmd_data,
    output logic                  cmd_ready,
    // read-back
    output logic                  rd_valid,
    output logic [SIO_WORD_W-1:0] rd_data,
    // toward the serial port
    output logic                  ph1,
    output logic                  imm_load,
    output logic                  acc_load,
    output logic                  ram_load,
    output sio_reg_e              r_field,
    output logic [SIO_WORD_W-1:0] long_imm,
    output logic [SIO_WORD_W-1:0] acc_dout,
    output logic [SIO_WORD_W-1:0] ram_dout,
    // from the serial port
    input  logic                  obe,
    input  logic [SIO_WORD_W-1:0] r_sio
);

    logic                  is_load;      // any op_load_* opcode
    logic                  is_sdx_load;  // load aimed at the output buffer
    logic                  accept;       // valid and ready this cycle
    logic [SIO_WORD_W-1:0] acc;
    logic [SIO_WORD_W-1:0] ram [RAM_DEPTH];

    // phase generator
    // 0 right after reset, then toggles every clk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ph1 <= 1'b0;
        end else begin
            ph1 <= ~ph1;
        end
    end

    assign is_load     = (cmd_op == op_load_imm) ||
                         (cmd_op == op_load_acc) ||
                         (cmd_op == op_load_ram);
    assign is_sdx_load = is_load && (cmd_reg == reg_sdx);

    // commands only go in on ph1 cycles
    // a data word also waits for the buffer to drain into the shifter
    assign cmd_ready = ph1 && (!is_sdx_load || obe);
    assign accept    = cmd_valid && cmd_ready;

    // one strobe per accepted load, all qualified by ph1 through accept
    assign imm_load = accept && (cmd_op == op_load_imm);
    assign acc_load = accept && (cmd_op == op_load_acc);
    assign ram_load = accept && (cmd_op == op_load_ram);

    // source buses, the port muxes them by strobe
    assign r_field  = cmd_reg;
    assign long_imm = cmd_data;          // immediate comes straight from the host
    assign acc_dout = acc;
    assign ram_dout = ram[cmd_addr];     // async read at the command address

    // accumulator
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (accept && (cmd_op == op_set_acc)) begin
            acc <= cmd_data;
        end
    end

    // data ram, written by op_set_ram
    always_ff @(posedge clk) begin
        if (accept && (cmd_op == op_set_ram)) begin
            ram[cmd_addr] <= cmd_data;
        end
    end

    // read-back strobe, one cycle after acceptance
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= accept && (cmd_op == op_read);
        end
    end

    // capture r_sio as seen at the accepting edge
    always_ff @(posedge clk) begin
        if (accept && (cmd_op == op_read)) begin
            rd_data <= r_sio;
        end
    end

endmodule

//--- logic/sio_serial_out.sv
/*
 * serial output port, fixed configuration
 * sioc/srta/sdx register writes and read mux
 * ock divider, 16 slot word ring, output buffer and shifter
 * inverted address shifted on sadd, obe/ose status flags
 */
module sio_serial_out
    import sio_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ph1,
    // load strobes and sources from the command side
    input  logic                  imm_load,
    input  logic                  acc_load,
    input  logic                  ram_load,
    input  sio_reg_e              r_field,
    input  logic [SIO_WORD_W-1:0] long_imm,
    input  logic [SIO_WORD_W-1:0] acc_dout,
    input  logic [SIO_WORD_W-1:0] ram_dout,
    // serial pins
    output logic                  ock,      // output clock
    output logic                  sio_do,   // data out, msb first
    output logic                  sadd,     // address out, active low
    output logic                  sio_old,  // output load, not generated
    output logic                  ose,      // output shifter empty
    output logic                  obe,      // output buffer empty
    output logic                  ibf,      // input buffer full, no input side
    // register read-back
    output logic [SIO_WORD_W-1:0] r_sio
);

    logic                  any_load;
    logic                  sdx_load;
    logic                  srta_load;
    logic                  sioc_load;
    logic [SIO_WORD_W-1:0] load_data;

    logic [SIOC_W-1:0]     sioc;        // kept for read-back only
    logic [SRTA_W-1:0]     srta;
    logic [SIO_WORD_W-1:0] obuf;        // output buffer
    logic [SIO_WORD_W-1:0] odata;       // bits still to shift after sio_do
    logic [SRTA_W-1:0]     addr_obuf;   // address shifter, drives sadd
    logic [SIO_WORD_W-1:0] ocnt;        // one hot word ring
    logic [OCK_DIV_W-1:0]  clkdiv;
    logic                  ock_rise;
    logic                  ock_fall;
    logic                  word_end;

    // strobe decode
    assign any_load  = imm_load || acc_load || ram_load;
    assign sdx_load  = any_load && (r_field == reg_sdx);
    assign srta_load = any_load && (r_field == reg_srta);
    assign sioc_load = any_load && (r_field == reg_sioc);
    assign load_data = imm_load ? long_imm :
                       acc_load ? acc_dout : ram_dout;

    // unsupported pins held at their idle level
    assign sio_old = 1'b1;
    assign ibf     = 1'b0;

    assign sadd     = addr_obuf[SRTA_W-1];
    assign ock_rise = (clkdiv == OCK_DIV_W'(OCK_RISE));
    assign ock_fall = (clkdiv == OCK_DIV_W'(OCK_FALL));
    assign word_end = ocnt[SIO_WORD_W-1];   // slot 15 of the ring

    // ock divider, counts ph1 ticks 0..OCK_DIV-1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clkdiv <= '0;
            ock    <= 1'b0;
        end else if (ph1) begin
            clkdiv <= (clkdiv == OCK_DIV_W'(OCK_DIV - 1)) ? '0 : clkdiv + 1'b1;
            if (ock_rise) ock <= 1'b1;
            if (ock_fall) ock <= 1'b0;
        end
    end

    // config and address registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sioc <= '0;
            srta <= '0;
        end else if (ph1) begin
            if (sioc_load) sioc <= load_data[SIOC_W-1:0];   // stored, never decoded
            if (srta_load) srta <= load_data[SRTA_W-1:0];
        end
    end

    // output buffer, only meaningful while obe is low
    always_ff @(posedge clk) begin
        if (ph1 && sdx_load) begin
            obuf <= load_data;
        end
    end

    // shifter, word ring and status flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ocnt      <= SIO_WORD_W'(1);
            odata     <= '0;
            sio_do    <= 1'b0;
            addr_obuf <= '1;         // sadd idles high
            obe       <= 1'b1;
            ose       <= 1'b1;
        end else if (ph1) begin
            if (sdx_load) obe <= 1'b0;    // new word waiting in obuf
            if (ock_rise) begin
                ocnt <= {ocnt[SIO_WORD_W-2:0], ocnt[SIO_WORD_W-1]};
                if (word_end && !obe) begin
                    // word boundary with data pending, start a frame
                    {sio_do, odata} <= {obuf, 1'b0};
                    addr_obuf       <= ~srta;   // address goes out inverted
                    obe             <= 1'b1;
                    ose             <= 1'b0;
                end else begin
                    {sio_do, odata} <= {odata, 1'b0};
                    addr_obuf       <= {addr_obuf[SRTA_W-2:0], 1'b1};  // fill with idle 1s
                    if (word_end) ose <= 1'b1;      // nothing queued, shifter drains
                end
            end
        end
    end

    // read mux, sdx reads as 0 since there is no input side
    always_comb begin
        case (r_field)
            reg_sioc: r_sio = SIO_WORD_W'(sioc);
            reg_srta: r_sio = SIO_WORD_W'(srta);
            default:  r_sio = '0;
        endcase
    end

endmodule

//--- logic/sio_top.sv
/*
 * top level of the serial output block
 * host command unit driving the serial output port
 */
module sio_top
    import sio_cfg_pkg::*;
    import sio_cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // host command port
    input  logic                  cmd_valid,
    input  sio_op_e               cmd_op,
    input  sio_reg_e              cmd_reg,
    input  logic [RAM_AW-1:0]     cmd_addr,
    input  logic [SIO_WORD_W-1:0] cmd_data,
    output logic                  cmd_ready,
    // read-back
    output logic                  rd_valid,
    output logic [SIO_WORD_W-1:0] rd_data,
    // serial pins
    output logic                  ock,
    output logic                  sio_do,
    output logic                  sadd,
    output logic                  sio_old,
    output logic                  ose,
    output logic                  ibf
);

    // command unit to port
    logic                  ph1;
    logic                  imm_load;
    logic                  acc_load;
    logic                  ram_load;
    sio_reg_e              r_field;
    logic [SIO_WORD_W-1:0] long_imm;
    logic [SIO_WORD_W-1:0] acc_dout;
    logic [SIO_WORD_W-1:0] ram_dout;
    // port back to command unit
    logic                  obe;      // stalls sdx loads
    logic [SIO_WORD_W-1:0] r_sio;

    sio_cmd_unit u_cmd (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_reg   (cmd_reg),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .cmd_ready (cmd_ready),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .ph1       (ph1),
        .imm_load  (imm_load),
        .acc_load  (acc_load),
        .ram_load  (ram_load),
        .r_field   (r_field),
        .long_imm  (long_imm),
        .acc_dout  (acc_dout),
        .ram_dout  (ram_dout),
        .obe       (obe),
        .r_sio     (r_sio)
    );

    sio_serial_out u_sio (
        .clk      (clk),
        .rst      (rst),
        .ph1      (ph1),
        .imm_load (imm_load),
        .acc_load (acc_load),
        .ram_load (ram_load),
        .r_field  (r_field),
        .long_imm (long_imm),
        .acc_dout (acc_dout),
        .ram_dout (ram_dout),
        .ock      (ock),
        .sio_do   (sio_do),
        .sadd     (sadd),
        .sio_old  (sio_old),
        .ose      (ose),
        .obe      (obe),
        .ibf      (ibf),
        .r_sio    (r_sio)
    );

endmodule

//--- run_sim.sh
#!/bin/bash
# build and run the serial port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_sio_top -o Vtb_sio_top

# the simulator exits non-zero on $fatal, the search below decides the result
out=$(./obj_dir/Vtb_sio_top) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- sources.f
logic/sio_cfg_pkg.sv
logic/sio_cmd_pkg.sv
logic/sio_cmd_unit.sv
logic/sio_serial_out.sv
logic/sio_top.sv
tests/sio_rx_monitor.sv
tests/tb_sio_top.sv

//--- tests/sio_rx_monitor.sv
/*
 * serial receiver for the testbench
 * samples sio_do and sadd on ock falling edges while ose is low
 * collects 16 data bits and the first 8 address bits per frame
 */
module sio_rx_monitor
    import sio_cfg_pkg::*;
(
    input logic rst,
    input logic ock,
    input logic sio_do,
    input logic sadd,
    input logic ose
);

    logic [SIO_WORD_W-1:0]        data_sr;   // data bits, msb arrives first
    logic [SRTA_W-1:0]            addr_sr;   // raw sadd bits, still inverted
    int                           bit_cnt;
    logic [SIO_WORD_W+SRTA_W-1:0] frames[$]; // {data, address} per frame, read by the tb

    // pins move on ock rise, so the fall is mid-bit
    always @(negedge ock or posedge rst) begin
        if (rst) begin
            data_sr = '0;
            addr_sr = '0;
            bit_cnt = 0;
        end else if (!ose) begin
            data_sr = {data_sr[SIO_WORD_W-2:0], sio_do};
            if (bit_cnt < SRTA_W) begin
                addr_sr = {addr_sr[SRTA_W-2:0], sadd};   // address only in the first 8 slots
            end
            bit_cnt = bit_cnt + 1;
            // back-to-back words keep ose low, so frames are cut by count
            if (bit_cnt == SIO_WORD_W) begin
                frames.push_back({data_sr, addr_sr});
                bit_cnt = 0;
            end
        end
    end

endmodule

//--- tests/tb_sio_top.sv
/*
 * testbench for sio_top
 * table of commands with expected frames and read values, applied in a loop
 * reference model of acc, ram, srta and sioc, lfsr data words
 * receiver probe on the serial pins, cycle limit watchdog
 */
module tb_sio_top
    import sio_cfg_pkg::*;
    import sio_cmd_pkg::*;
();

    localparam int NUM_ROWS       = 20;
    localparam int OCK_CLKS       = 2 * OCK_DIV;    // clk cycles per ock period
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 * OCK_CLKS + 100 * OCK_CLKS;

    typedef struct packed {
        sio_op_e               op;
        sio_reg_e              rg;
        logic [RAM_AW-1:0]     addr;
        logic [SIO_WORD_W-1:0] data;
        logic [SIO_WORD_W-1:0] exp;        // frame word or read value
        logic [SRTA_W-1:0]     exp_addr;   // sadd bits expected in the frame
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    sio_op_e               cmd_op;
    sio_reg_e              cmd_reg;
    logic [RAM_AW-1:0]     cmd_addr;
    logic [SIO_WORD_W-1:0] cmd_data;
    logic                  cmd_ready;
    logic                  rd_valid;
    logic [SIO_WORD_W-1:0] rd_data;
    logic                  ock;
    logic                  sio_do;
    logic                  sadd;
    logic                  sio_old;
    logic                  ose;
    logic                  ibf;

    row_t                         rows[NUM_ROWS];
    int                           n_rows;
    logic [SIO_WORD_W+SRTA_W-1:0] exp_frames[$];
    int                           checked;     // frames already compared
    int                           stall_cnt;   // ph1 cycles an sdx load waited on obe
    int                           cycle_cnt;
    logic [31:0]                  lfsr;
    // reference model state
    logic [SIO_WORD_W-1:0]        m_acc;
    logic [SIO_WORD_W-1:0]        m_ram[RAM_DEPTH];
    logic [SRTA_W-1:0]            m_srta;
    logic [SIOC_W-1:0]            m_sioc;

    sio_top DUT (.*);

    sio_rx_monitor mon (
        .rst    (rst),
        .ock    (ock),
        .sio_do (sio_do),
        .sadd   (sadd),
        .ose    (ose)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) fail_with("timeout, the DUT stopped making progress");
    end

    task fail_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task check_word(input logic [SIO_WORD_W-1:0] got, input logic [SIO_WORD_W-1:0] exp,
                    input int idx);
        if (got !== exp)
            fail_with($sformatf("ERROR at %0t: frame %0d data %h, expected %h",
                                $time, idx, got, exp));
    endtask

    task check_addr(input logic [SRTA_W-1:0] got, input logic [SRTA_W-1:0] exp, input int idx);
        if (got !== exp)
            fail_with($sformatf("ERROR at %0t: frame %0d address bits %h, expected %h",
                                $time, idx, got, exp));
    endtask

    task check_read(input logic [SIO_WORD_W-1:0] got, input logic [SIO_WORD_W-1:0] exp,
                    input sio_reg_e rg);
        if (got !== exp)
            fail_with($sformatf("ERROR at %0t: read of %s gave %h, expected %h",
                                $time, rg.name(), got, exp));
    endtask

    task check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_with($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [SIO_WORD_W-1:0] rand_word();
        logic [SIO_WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < SIO_WORD_W; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            w    = {w[SIO_WORD_W-2:0], lfsr[0]};
        end
        return w;
    endfunction

    // append a row while the model works out what the DUT should give back
    task add_row(input sio_op_e op, input sio_reg_e rg, input logic [RAM_AW-1:0] addr);
        row_t                  r;
        logic [SIO_WORD_W-1:0] val;
        r = '{op: op, rg: rg, addr: addr, data: '0, exp: '0, exp_addr: ~m_srta};
        if (op == op_set_acc || op == op_set_ram || op == op_load_imm) r.data = rand_word();
        case (op)
            op_set_acc: m_acc = r.data;
            op_set_ram: m_ram[addr] = r.data;
            op_read: begin
                if (rg == reg_sioc) r.exp = SIO_WORD_W'(m_sioc);
                else if (rg == reg_srta) r.exp = SIO_WORD_W'(m_srta);
            end
            default: begin
                val = (op == op_load_imm) ? r.data :
                      (op == op_load_acc) ? m_acc : m_ram[addr];
                if (rg == reg_sioc) m_sioc = val[SIOC_W-1:0];
                else if (rg == reg_srta) m_srta = val[SRTA_W-1:0];
                else r.exp = val;                  // sdx word goes out as one frame
            end
        endcase
        rows[n_rows] = r;
        n_rows++;
    endtask

    task build_table;
        add_row(op_load_imm, reg_sdx,  0);   // address still at reset value
        add_row(op_read,     reg_srta, 0);
        add_row(op_read,     reg_sdx,  0);
        add_row(op_load_imm, reg_sioc, 0);
        add_row(op_read,     reg_sioc, 0);
        add_row(op_load_imm, reg_srta, 0);
        add_row(op_read,     reg_srta, 0);
        add_row(op_load_imm, reg_sdx,  0);   // burst of data loads from here
        add_row(op_set_acc,  reg_sdx,  0);
        add_row(op_load_acc, reg_sdx,  0);
        add_row(op_set_ram,  reg_sdx,  3);
        add_row(op_set_ram,  reg_sdx,  6);
        add_row(op_load_ram, reg_sdx,  6);
        add_row(op_load_ram, reg_sdx,  3);
        add_row(op_load_imm, reg_sdx,  0);
        add_row(op_load_acc, reg_srta, 0);
        add_row(op_load_ram, reg_sdx,  3);
        add_row(op_load_imm, reg_sdx,  0);
        add_row(op_read,     reg_srta, 0);
        add_row(op_read,     reg_sioc, 0);
    endtask

    // called on a falling edge and returns on the falling edge after acceptance
    task send_cmd(input row_t r);
        logic data_load;   // load aimed at the output buffer
        data_load = (r.rg == reg_sdx) &&
                    (r.op == op_load_imm || r.op == op_load_acc || r.op == op_load_ram);
        cmd_valid = 1'b1;
        cmd_op    = r.op;
        cmd_reg   = r.rg;
        cmd_addr  = r.addr;
        cmd_data  = r.data;
        #1;
        while (!cmd_ready) begin
            if (DUT.ph1) begin
                // on ph1 only a data word behind a full buffer may wait
                check_flag(data_load, 1'b1, "command held on a ph1 cycle");
                check_flag(DUT.obe, 1'b0, "obe while a data load is held");
                stall_cnt++;
            end
            @(negedge clk);
            #1;
        end
        @(posedge clk);   // taken here
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // wait for every issued data word, then compare in issue order
    task drain_frames;
        logic [SIO_WORD_W+SRTA_W-1:0] seen;
        logic [SIO_WORD_W+SRTA_W-1:0] want;
        while (mon.frames.size() < exp_frames.size()) @(negedge clk);
        if (mon.frames.size() > exp_frames.size()) fail_with("more frames seen than words loaded");
        while (checked < exp_frames.size()) begin
            seen = mon.frames[checked];
            want = exp_frames[checked];
            check_word(seen[SIO_WORD_W+SRTA_W-1:SRTA_W], want[SIO_WORD_W+SRTA_W-1:SRTA_W],
                       checked);
            check_addr(seen[SRTA_W-1:0], want[SRTA_W-1:0], checked);
            checked++;
        end
    endtask

    task apply_row(input row_t r);
        if (r.rg == reg_srta && r.op != op_read) drain_frames();   // srta is taken at frame start
        send_cmd(r);
        if (r.op == op_read) begin
            while (!rd_valid) @(negedge clk);
            check_read(rd_data, r.exp, r.rg);
        end else if (r.rg == reg_sdx && r.op != op_set_acc && r.op != op_set_ram) begin
            exp_frames.push_back({r.exp, r.exp_addr});
        end
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = op_set_acc;
        cmd_reg   = reg_sioc;
        cmd_addr  = '0;
        cmd_data  = '0;
        cycle_cnt = 0;
        n_rows    = 0;
        checked   = 0;
        stall_cnt = 0;
        lfsr      = 32'h4973;
        m_acc     = '0;
        m_srta    = '0;
        m_sioc    = '0;
        foreach (m_ram[i]) m_ram[i] = '0;
        build_table();

        repeat (5) @(negedge clk);
        rst = 1'b0;
        // idle levels straight out of reset
        check_flag(ose, 1'b1, "ose after reset");
        check_flag(DUT.obe, 1'b1, "obe after reset");
        check_flag(ock, 1'b0, "ock after reset");
        check_flag(sadd, 1'b1, "sadd after reset");
        check_flag(sio_do, 1'b0, "sio_do after reset");
        check_flag(cmd_ready, 1'b0, "cmd_ready after reset");
        check_flag(rd_valid, 1'b0, "rd_valid after reset");
        check_flag(sio_old, 1'b1, "sio_old");
        check_flag(ibf, 1'b0, "ibf");

        for (int i = 0; i < n_rows; i++) apply_row(rows[i]);

        drain_frames();
        @(posedge ock);   // the rise that closes the last word
        @(negedge clk);
        check_flag(ose, 1'b1, "ose after last frame");
        check_flag(DUT.obe, 1'b1, "obe after last frame");

        if (stall_cnt == 0) begin
            fail_with("back-to-back data loads were never held off while obe was low");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
